//--- src/mfp_bus_pkg.sv
package mfp_bus_pkg;

    // ------------------------------------------------------------------------
    // AHB-Lite field types
    // ------------------------------------------------------------------------

    typedef logic [31:0] haddr_t;
    typedef logic [31:0] hdata_t;
    typedef logic [2:0]  hsize_t;
    typedef logic [1:0]  htrans_t;

    // One bit per byte lane, lane 0 is hdata_t bits 7:0
    typedef logic [3:0]  byte_en_t;

    // ------------------------------------------------------------------------
    // Transfer codes
    // ------------------------------------------------------------------------

    // The core issues single transfers only, so SEQ and BUSY never appear
    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;

    localparam hsize_t HSIZE_BYTE = 3'b000;
    localparam hsize_t HSIZE_HALF = 3'b001;
    localparam hsize_t HSIZE_WORD = 3'b010;   // Widest size on a 32-bit bus

endpackage

//--- src/mfp_map_pkg.sv
package mfp_map_pkg;

    // ------------------------------------------------------------------------
    // Devices on the matrix
    // ------------------------------------------------------------------------

    localparam int DEVICE_COUNT = 3;

    // Index into dev_sel_t, lower index wins in the response mux
    localparam int DEV_RESET_RAM = 0;
    localparam int DEV_RAM       = 1;
    localparam int DEV_GPIO      = 2;

    typedef logic [DEVICE_COUNT-1:0] dev_sel_t;

    // ------------------------------------------------------------------------
    // Address match values (physical addresses, kseg bits 31:29 ignored)
    // ------------------------------------------------------------------------

    // Boot RAM, 4 MB window at 0x1fc00000, bits 28:22
    localparam logic [6:0] RESET_RAM_MATCH = 7'h7f;

    // Main RAM, 64 MB window at 0x00000000, bits 28:26
    localparam logic [2:0] RAM_MATCH = 3'h0;

    // GPIO, 4 MB window at 0x1f800000, bits 28:22
    localparam logic [6:0] GPIO_MATCH = 7'h7e;

    // GPIO register word offsets (address bits 3:2)
    localparam logic [1:0] GPIO_REG_RED      = 2'd0;
    localparam logic [1:0] GPIO_REG_GREEN    = 2'd1;
    localparam logic [1:0] GPIO_REG_SWITCHES = 2'd2;   // Read only
    localparam logic [1:0] GPIO_REG_BUTTONS  = 2'd3;   // Read only

endpackage

//--- src/ahb_slave_if.sv
`timescale 1ns/100ps

interface ahb_slave_if;

    // Master fields, fanned out by the select stage
    mfp_bus_pkg::haddr_t  haddr;
    logic                 hwrite;
    mfp_bus_pkg::hsize_t  hsize;
    mfp_bus_pkg::htrans_t htrans;
    mfp_bus_pkg::hdata_t  hwdata;   // Data phase
    logic                 hsel;     // Address phase select
    logic                 hready;   // Global ready from the response mux

    // Slave response
    mfp_bus_pkg::hdata_t  hrdata;
    logic                 hreadyout;
    logic                 hresp;

    modport slave (
        input  haddr, hwrite, hsize, htrans, hwdata, hsel, hready,
        output hrdata, hreadyout, hresp
    );

    modport matrix (
        output haddr, hwrite, hsize, htrans, hwdata, hsel, hready,
        input  hrdata, hreadyout, hresp
    );

endinterface

//--- src/ahb_select_stage.sv
`timescale 1ns/100ps

module ahb_select_stage (
    input  logic                  hclk,
    input  logic                  rst,
    input  mfp_bus_pkg::haddr_t   haddr,
    input  mfp_bus_pkg::hsize_t   hsize,
    input  mfp_bus_pkg::htrans_t  htrans,
    input  mfp_bus_pkg::hdata_t   hwdata,
    input  logic                  hwrite,
    input  logic                  hready,
    ahb_slave_if.matrix           reset_ram_bus,
    ahb_slave_if.matrix           ram_bus,
    ahb_slave_if.matrix           gpio_bus,
    output mfp_map_pkg::dev_sel_t sel_r
);

    mfp_map_pkg::dev_sel_t hsel;

    // ------------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------------

    assign hsel[mfp_map_pkg::DEV_RESET_RAM] = (haddr[28:22] == mfp_map_pkg::RESET_RAM_MATCH);
    assign hsel[mfp_map_pkg::DEV_RAM]       = (haddr[28:26] == mfp_map_pkg::RAM_MATCH);
    assign hsel[mfp_map_pkg::DEV_GPIO]      = (haddr[28:22] == mfp_map_pkg::GPIO_MATCH);

    // Fan out to the slaves
    assign reset_ram_bus.hsel   = hsel[mfp_map_pkg::DEV_RESET_RAM];
    assign reset_ram_bus.haddr  = haddr;
    assign reset_ram_bus.hwrite = hwrite;
    assign reset_ram_bus.hsize  = hsize;
    assign reset_ram_bus.htrans = htrans;
    assign reset_ram_bus.hwdata = hwdata;

    assign ram_bus.hsel   = hsel[mfp_map_pkg::DEV_RAM];
    assign ram_bus.haddr  = haddr;
    assign ram_bus.hwrite = hwrite;
    assign ram_bus.hsize  = hsize;
    assign ram_bus.htrans = htrans;
    assign ram_bus.hwdata = hwdata;

    assign gpio_bus.hsel   = hsel[mfp_map_pkg::DEV_GPIO];
    assign gpio_bus.haddr  = haddr;
    assign gpio_bus.hwrite = hwrite;
    assign gpio_bus.hsize  = hsize;
    assign gpio_bus.htrans = htrans;
    assign gpio_bus.hwdata = hwdata;

    // Data-phase select, held while a slave stretches the transfer
    always_ff @(posedge hclk) begin
        if (rst)
            sel_r <= '0;
        else if (hready)
            sel_r <= hsel;
    end

    // Memory map windows must not overlap for any real transfer
    a_decode_onehot: assert property (@(posedge hclk) disable iff (rst)
        (htrans != mfp_bus_pkg::HTRANS_IDLE) |-> $onehot0(hsel))
        else $error("Overlapping decode at address %h", haddr);

endmodule

//--- src/ahb_ram_slave.sv
`timescale 1ns/100ps

module ahb_ram_slave #(
    parameter int ADDR_WIDTH  = 8,
    parameter int WAIT_STATES = 0
) (
    input  logic       hclk,
    input  logic       rst,
    ahb_slave_if.slave bus
);

    localparam int CNT_WIDTH = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    mfp_bus_pkg::hdata_t   mem [2**ADDR_WIDTH];
    logic [ADDR_WIDTH-1:0] addr_r;       // Word address of the data phase
    mfp_bus_pkg::byte_en_t be_next;
    mfp_bus_pkg::byte_en_t be_r;
    logic                  write_r;
    logic                  active;       // Data phase in progress
    logic [CNT_WIDTH-1:0]  wait_cnt;
    logic                  accept;

    assign accept = bus.hsel && bus.hready && (bus.htrans == mfp_bus_pkg::HTRANS_NONSEQ);

    // Little-endian lane enables
    always_comb begin
        case (bus.hsize)
            mfp_bus_pkg::HSIZE_BYTE: be_next = 4'b0001 << bus.haddr[1:0];
            mfp_bus_pkg::HSIZE_HALF: be_next = bus.haddr[1] ? 4'b1100 : 4'b0011;
            mfp_bus_pkg::HSIZE_WORD: be_next = 4'b1111;
            default:                 be_next = 4'b0000;   // No lanes for wider sizes
        endcase
    end

    // ------------------------------------------------------------------------
    // Address phase and wait-state counter
    // ------------------------------------------------------------------------

    always_ff @(posedge hclk) begin
        if (rst) begin
            active   <= 1'b0;
            wait_cnt <= '0;
        end else if (bus.hready) begin
            active   <= accept;
            wait_cnt <= accept ? CNT_WIDTH'(WAIT_STATES) : '0;
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - CNT_WIDTH'(1);
        end
    end

    always_ff @(posedge hclk) begin
        if (accept) begin
            addr_r  <= bus.haddr[ADDR_WIDTH+1:2];
            be_r    <= be_next;
            write_r <= bus.hwrite;
        end
    end

    // ------------------------------------------------------------------------
    // Data phase
    // ------------------------------------------------------------------------

    // Write lands on the edge that ends the data phase
    always_ff @(posedge hclk) begin
        if (active && write_r && bus.hready) begin
            for (int i = 0; i < 4; i++) begin
                if (be_r[i])
                    mem[addr_r][8*i +: 8] <= bus.hwdata[8*i +: 8];
            end
        end
    end

    assign bus.hreadyout = (wait_cnt == '0);
    assign bus.hrdata    = mem[addr_r];
    assign bus.hresp     = 1'b0;

    // Every accepted transfer completes after its wait states
    a_wait_bound: assert property (@(posedge hclk) disable iff (rst)
        accept |-> ##(WAIT_STATES + 1) bus.hreadyout)
        else $error("RAM stalled longer than %0d wait states", WAIT_STATES);

endmodule

//--- src/ahb_gpio_slave.sv
`timescale 1ns/100ps

module ahb_gpio_slave #(
    parameter int N_RED_LEDS   = 18,
    parameter int N_GREEN_LEDS = 8,
    parameter int N_SWITCHES   = 18,
    parameter int N_BUTTONS    = 4
) (
    input  logic                    hclk,
    input  logic                    rst,
    ahb_slave_if.slave              bus,
    input  logic [N_SWITCHES-1:0]   switches,
    input  logic [N_BUTTONS-1:0]    buttons,
    output logic [N_RED_LEDS-1:0]   red_leds,
    output logic [N_GREEN_LEDS-1:0] green_leds
);

    logic       active;
    logic       write_r;
    logic [1:0] reg_r;     // Word offset of the current data phase

    always_ff @(posedge hclk) begin
        if (rst)
            active <= 1'b0;
        else if (bus.hready)
            active <= bus.hsel && (bus.htrans == mfp_bus_pkg::HTRANS_NONSEQ);
    end

    always_ff @(posedge hclk) begin
        if (bus.hready) begin
            reg_r   <= bus.haddr[3:2];
            write_r <= bus.hwrite;
        end
    end

    // LED registers
    always_ff @(posedge hclk) begin
        if (rst) begin
            red_leds   <= '0;
            green_leds <= '0;
        end else if (active && write_r && bus.hready) begin
            case (reg_r)
                mfp_map_pkg::GPIO_REG_RED:   red_leds   <= bus.hwdata[N_RED_LEDS-1:0];
                mfp_map_pkg::GPIO_REG_GREEN: green_leds <= bus.hwdata[N_GREEN_LEDS-1:0];
                default: ;   // Switches and buttons are inputs
            endcase
        end
    end

    // Read back, zero-extended to the bus width
    always_comb begin
        case (reg_r)
            mfp_map_pkg::GPIO_REG_RED:      bus.hrdata = mfp_bus_pkg::hdata_t'(red_leds);
            mfp_map_pkg::GPIO_REG_GREEN:    bus.hrdata = mfp_bus_pkg::hdata_t'(green_leds);
            mfp_map_pkg::GPIO_REG_SWITCHES: bus.hrdata = mfp_bus_pkg::hdata_t'(switches);
            mfp_map_pkg::GPIO_REG_BUTTONS:  bus.hrdata = mfp_bus_pkg::hdata_t'(buttons);
        endcase
    end

    assign bus.hreadyout = 1'b1;   // Zero wait states
    assign bus.hresp     = 1'b0;

endmodule

//--- src/ahb_response_mux.sv
`timescale 1ns/100ps

module ahb_response_mux (
    input  mfp_map_pkg::dev_sel_t sel_r,
    ahb_slave_if.matrix           reset_ram_bus,
    ahb_slave_if.matrix           ram_bus,
    ahb_slave_if.matrix           gpio_bus,
    output mfp_bus_pkg::hdata_t   hrdata,
    output logic                  hready,
    output logic                  hresp
);

    // Lowest set index wins
    always_comb begin
        // The select register owns at most one data phase at a time
        a_sel_onehot: assert #0 ($isunknown(sel_r) || $onehot0(sel_r))
            else $error("Data-phase select %b is not one-hot", sel_r);

        if (sel_r[mfp_map_pkg::DEV_RESET_RAM]) begin
            hrdata = reset_ram_bus.hrdata;
            hready = reset_ram_bus.hreadyout;
            hresp  = reset_ram_bus.hresp;
        end else if (sel_r[mfp_map_pkg::DEV_GPIO] && !sel_r[mfp_map_pkg::DEV_RAM]) begin
            hrdata = gpio_bus.hrdata;
            hready = gpio_bus.hreadyout;
            hresp  = gpio_bus.hresp;
        end else begin
            // Main RAM, also taken when nothing is selected
            hrdata = ram_bus.hrdata;
            hready = ram_bus.hreadyout;
            hresp  = ram_bus.hresp;
        end
    end

    // Global ready back to every slave
    assign reset_ram_bus.hready = hready;
    assign ram_bus.hready       = hready;
    assign gpio_bus.hready      = hready;

endmodule

//--- src/mfp_ahb_lite_matrix.sv
`timescale 1ns/100ps

module mfp_ahb_lite_matrix #(
    parameter int RESET_RAM_ADDR_WIDTH = 8,
    parameter int RAM_ADDR_WIDTH       = 10,
    parameter int RAM_WAIT_STATES      = 2,
    parameter int N_RED_LEDS           = 18,
    parameter int N_GREEN_LEDS         = 8,
    parameter int N_SWITCHES           = 18,
    parameter int N_BUTTONS            = 4
) (
    input  logic                    hclk,
    input  logic                    rst,
    input  mfp_bus_pkg::haddr_t     haddr,
    input  mfp_bus_pkg::hsize_t     hsize,
    input  mfp_bus_pkg::htrans_t    htrans,
    input  mfp_bus_pkg::hdata_t     hwdata,
    input  logic                    hwrite,
    output mfp_bus_pkg::hdata_t     hrdata,
    output logic                    hready,
    output logic                    hresp,
    input  logic [N_SWITCHES-1:0]   io_switches,
    input  logic [N_BUTTONS-1:0]    io_buttons,
    output logic [N_RED_LEDS-1:0]   io_red_leds,
    output logic [N_GREEN_LEDS-1:0] io_green_leds
);

    mfp_map_pkg::dev_sel_t sel_r;   // Data-phase select

    ahb_slave_if reset_ram_bus ();
    ahb_slave_if ram_bus ();
    ahb_slave_if gpio_bus ();

    ahb_select_stage select_stage (
        .hclk          (hclk),
        .rst           (rst),
        .haddr         (haddr),
        .hsize         (hsize),
        .htrans        (htrans),
        .hwdata        (hwdata),
        .hwrite        (hwrite),
        .hready        (hready),
        .reset_ram_bus (reset_ram_bus),
        .ram_bus       (ram_bus),
        .gpio_bus      (gpio_bus),
        .sel_r         (sel_r)
    );

    // ------------------------------------------------------------------------
    // Slaves
    // ------------------------------------------------------------------------

    ahb_ram_slave #(
        .ADDR_WIDTH  (RESET_RAM_ADDR_WIDTH),
        .WAIT_STATES (0)
    ) reset_ram (
        .hclk (hclk),
        .rst  (rst),
        .bus  (reset_ram_bus)
    );

    ahb_ram_slave #(
        .ADDR_WIDTH  (RAM_ADDR_WIDTH),
        .WAIT_STATES (RAM_WAIT_STATES)
    ) ram (
        .hclk (hclk),
        .rst  (rst),
        .bus  (ram_bus)
    );

    ahb_gpio_slave #(
        .N_RED_LEDS   (N_RED_LEDS),
        .N_GREEN_LEDS (N_GREEN_LEDS),
        .N_SWITCHES   (N_SWITCHES),
        .N_BUTTONS    (N_BUTTONS)
    ) gpio (
        .hclk       (hclk),
        .rst        (rst),
        .bus        (gpio_bus),
        .switches   (io_switches),
        .buttons    (io_buttons),
        .red_leds   (io_red_leds),
        .green_leds (io_green_leds)
    );

    ahb_response_mux response_mux (
        .sel_r         (sel_r),
        .reset_ram_bus (reset_ram_bus),
        .ram_bus       (ram_bus),
        .gpio_bus      (gpio_bus),
        .hrdata        (hrdata),
        .hready        (hready),
        .hresp         (hresp)
    );

endmodule

//--- dv/tb_matrix.sv
`timescale 1ns/100ps

module tb_matrix;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int RAM_WAIT_STATES = 2;
    localparam int N_RED_LEDS      = 18;
    localparam int N_GREEN_LEDS    = 8;
    localparam int N_SWITCHES      = 18;
    localparam int N_BUTTONS       = 4;

    localparam logic [31:0] RESET_RAM_BASE = 32'h1fc0_0000;
    localparam logic [31:0] RAM_BASE       = 32'h0000_0000;
    localparam logic [31:0] GPIO_BASE      = 32'h1f80_0000;
    localparam logic [31:0] UNMAPPED_ADDR  = 32'h1040_0000;

    localparam int N_WORDS       = 6;    // Per RAM region
    localparam int N_LANE_WRITES = 6;
    localparam int N_PAIRS       = 4;
    localparam int N_GPIO_XFERS  = 10;

    // Last term is the unmapped test, which reads back every model word and both LED registers
    localparam int TRANSFER_COUNT = 4*N_WORDS + 1 + 2*N_LANE_WRITES + 2*N_PAIRS + N_GPIO_XFERS
                                    + 1 + (2*N_WORDS + 1 + N_PAIRS) + 2;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 200*TRANSFER_COUNT;
    localparam int READY_LIMIT    = RAM_WAIT_STATES + 8;

    logic                    hclk;
    logic                    rst;
    logic [31:0]             haddr;
    logic [2:0]              hsize;
    logic [1:0]              htrans;
    logic [31:0]             hwdata;
    logic                    hwrite;
    logic [31:0]             hrdata;
    logic                    hready;
    logic                    hresp;
    logic [N_SWITCHES-1:0]   io_switches;
    logic [N_BUTTONS-1:0]    io_buttons;
    logic [N_RED_LEDS-1:0]   io_red_leds;
    logic [N_GREEN_LEDS-1:0] io_green_leds;

    logic [31:0] ram_model [logic [31:0]];   // Keyed by word-aligned byte address
    logic [31:0] red_written   = '0;         // Last values written to the LED registers
    logic [31:0] green_written = '0;
    logic [31:0] lfsr_state = 32'h521e;
    int          mismatches = 0;
    int          failures   = 0;

    mfp_ahb_lite_matrix #(
        .RESET_RAM_ADDR_WIDTH (8),
        .RAM_ADDR_WIDTH       (10),
        .RAM_WAIT_STATES      (RAM_WAIT_STATES),
        .N_RED_LEDS           (N_RED_LEDS),
        .N_GREEN_LEDS         (N_GREEN_LEDS),
        .N_SWITCHES           (N_SWITCHES),
        .N_BUTTONS            (N_BUTTONS)
    ) dut_i (
        .hclk          (hclk),
        .rst           (rst),
        .haddr         (haddr),
        .hsize         (hsize),
        .htrans        (htrans),
        .hwdata        (hwdata),
        .hwrite        (hwrite),
        .hrdata        (hrdata),
        .hready        (hready),
        .hresp         (hresp),
        .io_switches   (io_switches),
        .io_buttons    (io_buttons),
        .io_red_leds   (io_red_leds),
        .io_green_leds (io_green_leds)
    );

    initial begin
        hclk = 1'b0;
        forever #(CLK_PERIOD/2) hclk = ~hclk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge hclk);
        $display("Watchdog expired after %0d cycles, the bus stopped making progress",
                 TIMEOUT_CYCLES);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        $display("FAIL: see errors above");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Stimulus data and reference model
    // ------------------------------------------------------------------------

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function logic [31:0] random_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    // Little-endian, the byte or halfword sits at its own address within the word
    function automatic logic [31:0] merge_write(input logic [31:0] old, input logic [31:0] data,
                                                input logic [2:0] size, input logic [1:0] low);
        logic [31:0] w;
        w = old;
        case (size)
            mfp_bus_pkg::HSIZE_BYTE: w[8*low +: 8] = data[8*low +: 8];
            mfp_bus_pkg::HSIZE_HALF: w[16*low[1] +: 16] = data[16*low[1] +: 16];
            default:                 w = data;
        endcase
        return w;
    endfunction

    // Main RAM window is address bits 28:26 all zero
    function automatic bit in_main_ram(input logic [31:0] addr);
        return addr[28:26] == 3'h0;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        mismatches++;
        $display("Fail %s: expected %h, actual %h", name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("Error: %s", what);
    endtask

    // ------------------------------------------------------------------------
    // Bus tasks driving on the falling edge
    // ------------------------------------------------------------------------

    task automatic start_address(input logic [31:0] addr, input logic [2:0] size,
                                 input logic write);
        haddr  = addr;
        hsize  = size;
        hwrite = write;
        htrans = mfp_bus_pkg::HTRANS_NONSEQ;
    endtask

    // Returns at the falling edge just before the edge that ends the data phase
    task automatic wait_ready(input string name, input bit slow);
        int low;
        low = 0;
        while (hready !== 1'b1 && low < READY_LIMIT) begin
            low++;
            @(negedge hclk);
        end
        if (hready !== 1'b1)
            report_failure($sformatf("%s: hready still low after %0d cycles", name, low));
        else if (slow && (low < 1 || low > RAM_WAIT_STATES))
            report_failure($sformatf("%s: main RAM stalled %0d cycles, expected 1 to %0d",
                                     name, low, RAM_WAIT_STATES));
        else if (!slow && low != 0)
            report_failure($sformatf("%s: zero-wait slave stalled %0d cycles", name, low));
        if (hresp !== 1'b0)
            report_mismatch({name, " hresp"}, 32'h0, 32'(hresp));
    endtask

    task automatic ahb_write(input string name, input logic [31:0] addr, input logic [2:0] size,
                             input logic [31:0] data);
        @(negedge hclk);
        start_address(addr, size, 1'b1);
        @(negedge hclk);
        htrans = mfp_bus_pkg::HTRANS_IDLE;
        hwdata = data;
        wait_ready(name, in_main_ram(addr));
    endtask

    task automatic ahb_read(input string name, input logic [31:0] addr,
                            output logic [31:0] data);
        @(negedge hclk);
        start_address(addr, mfp_bus_pkg::HSIZE_WORD, 1'b0);
        @(negedge hclk);
        htrans = mfp_bus_pkg::HTRANS_IDLE;
        wait_ready(name, in_main_ram(addr));
        data = hrdata;
    endtask

    // Read address phase overlaps the write data phase
    task automatic write_then_read(input string name, input logic [31:0] addr,
                                   input logic [31:0] data, output logic [31:0] rdata);
        @(negedge hclk);
        start_address(addr, mfp_bus_pkg::HSIZE_WORD, 1'b1);
        @(negedge hclk);
        hwdata = data;
        start_address(addr, mfp_bus_pkg::HSIZE_WORD, 1'b0);
        wait_ready({name, " write"}, in_main_ram(addr));
        @(negedge hclk);
        htrans = mfp_bus_pkg::HTRANS_IDLE;
        wait_ready({name, " read"}, in_main_ram(addr));
        rdata = hrdata;
    endtask

    task automatic ram_write(input string name, input logic [31:0] addr, input logic [2:0] size,
                             input logic [31:0] data);
        logic [31:0] key;
        logic [31:0] old;
        key = {addr[31:2], 2'b00};
        old = ram_model.exists(key) ? ram_model[key] : 32'h0;
        ahb_write(name, addr, size, data);
        ram_model[key] = merge_write(old, data, size, addr[1:0]);
    endtask

    task automatic check_word(input string name, input logic [31:0] addr);
        logic [31:0] key;
        logic [31:0] rdata;
        key = {addr[31:2], 2'b00};
        ahb_read(name, key, rdata);
        if (rdata !== ram_model[key])
            report_mismatch($sformatf("%s @%h", name, key), ram_model[key], rdata);
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------

    task automatic test_reset();
        if (hready !== 1'b1)
            report_mismatch("reset hready", 32'h1, 32'(hready));
        if (hresp !== 1'b0)
            report_mismatch("reset hresp", 32'h0, 32'(hresp));
        if (io_red_leds !== '0)
            report_mismatch("reset red leds", 32'h0, 32'(io_red_leds));
        if (io_green_leds !== '0)
            report_mismatch("reset green leds", 32'h0, 32'(io_green_leds));
    endtask

    task automatic test_word_rw();
        for (int i = 0; i < N_WORDS; i++) begin
            ram_write("word_rw", RESET_RAM_BASE + 32'(i) * 32'h14, mfp_bus_pkg::HSIZE_WORD,
                      random_word());
            ram_write("word_rw", RAM_BASE + 32'(i) * 32'h24, mfp_bus_pkg::HSIZE_WORD,
                      random_word());
        end
        for (int i = 0; i < N_WORDS; i++) begin
            check_word("word_rw", RESET_RAM_BASE + 32'(i) * 32'h14);
            check_word("word_rw", RAM_BASE + 32'(i) * 32'h24);
        end
    endtask

    task automatic test_lanes();
        logic [31:0] base;
        logic [2:0]  size;
        logic [1:0]  low;
        base = RAM_BASE + 32'h200;
        ram_write("lanes", base, mfp_bus_pkg::HSIZE_WORD, random_word());
        for (int i = 0; i < N_LANE_WRITES; i++) begin
            size = (i < 4) ? mfp_bus_pkg::HSIZE_BYTE : mfp_bus_pkg::HSIZE_HALF;
            low  = (i < 4) ? 2'(i) : 2'(2*(i-4));   // Four bytes, then both halves
            ram_write("lanes", base + 32'(low), size, random_word());
            check_word($sformatf("lanes %0d", i), base);
        end
    endtask

    task automatic test_pipelined();
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rdata;
        for (int i = 0; i < N_PAIRS; i++) begin
            addr = RAM_BASE + 32'h300 + 32'(4*i);
            data = random_word();
            write_then_read("pipelined", addr, data, rdata);
            ram_model[addr] = data;
            if (rdata !== data)
                report_mismatch($sformatf("pipelined @%h", addr), data, rdata);
        end
    endtask

    task automatic test_gpio();
        logic [31:0] red;
        logic [31:0] green;
        logic [31:0] inputs;
        logic [31:0] rdata;
        red   = 32'(random_word() & ((32'h1 << N_RED_LEDS) - 1));
        green = 32'(random_word() & ((32'h1 << N_GREEN_LEDS) - 1));
        red_written   = red;
        green_written = green;
        ahb_write("gpio red", GPIO_BASE + 32'h0, mfp_bus_pkg::HSIZE_WORD, red | 32'hfff0_0000);
        ahb_write("gpio green", GPIO_BASE + 32'h4, mfp_bus_pkg::HSIZE_WORD,
                  green | 32'hffff_ff00);   // High bits fall off at the port width
        @(negedge hclk);
        if (32'(io_red_leds) !== red)
            report_mismatch("gpio red port", red, 32'(io_red_leds));
        if (32'(io_green_leds) !== green)
            report_mismatch("gpio green port", green, 32'(io_green_leds));
        ahb_read("gpio red read", GPIO_BASE + 32'h0, rdata);
        if (rdata !== red)
            report_mismatch("gpio red read", red, rdata);
        ahb_read("gpio green read", GPIO_BASE + 32'h4, rdata);
        if (rdata !== green)
            report_mismatch("gpio green read", green, rdata);

        inputs      = random_word();
        io_switches = inputs[N_SWITCHES-1:0];
        io_buttons  = inputs[31:32-N_BUTTONS];
        ahb_read("gpio switches", GPIO_BASE + 32'h8, rdata);
        if (rdata !== 32'(io_switches))
            report_mismatch("gpio switches", 32'(io_switches), rdata);
        ahb_read("gpio buttons", GPIO_BASE + 32'hc, rdata);
        if (rdata !== 32'(io_buttons))
            report_mismatch("gpio buttons", 32'(io_buttons), rdata);

        // Switch offset is read only
        ahb_write("gpio switch write", GPIO_BASE + 32'h8, mfp_bus_pkg::HSIZE_WORD, random_word());
        @(negedge hclk);
        if (32'(io_red_leds) !== red)
            report_mismatch("gpio switch write red", red, 32'(io_red_leds));
        if (32'(io_green_leds) !== green)
            report_mismatch("gpio switch write green", green, 32'(io_green_leds));
        ahb_read("gpio switches again", GPIO_BASE + 32'h8, rdata);
        if (rdata !== 32'(io_switches))
            report_mismatch("gpio switches again", 32'(io_switches), rdata);
        ahb_read("gpio red again", GPIO_BASE + 32'h0, rdata);
        if (rdata !== red)
            report_mismatch("gpio red again", red, rdata);
        ahb_read("gpio green again", GPIO_BASE + 32'h4, rdata);
        if (rdata !== green)
            report_mismatch("gpio green again", green, rdata);
    endtask

    task automatic test_unmapped();
        logic [31:0] red;
        logic [31:0] green;
        logic [31:0] key;
        logic [31:0] rdata;
        red   = red_written;
        green = green_written;
        ahb_write("unmapped", UNMAPPED_ADDR, mfp_bus_pkg::HSIZE_WORD, random_word());
        @(negedge hclk);
        if (hready !== 1'b1)
            report_mismatch("unmapped hready", 32'h1, 32'(hready));
        if (32'(io_red_leds) !== red)
            report_mismatch("unmapped red port", red, 32'(io_red_leds));
        if (32'(io_green_leds) !== green)
            report_mismatch("unmapped green port", green, 32'(io_green_leds));
        if (ram_model.first(key)) begin
            do begin
                check_word("unmapped", key);
            end while (ram_model.next(key));
        end
        ahb_read("unmapped red read", GPIO_BASE + 32'h0, rdata);
        if (rdata !== red)
            report_mismatch("unmapped red read", red, rdata);
        ahb_read("unmapped green read", GPIO_BASE + 32'h4, rdata);
        if (rdata !== green)
            report_mismatch("unmapped green read", green, rdata);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        rst         = 1'b1;
        haddr       = '0;
        hsize       = mfp_bus_pkg::HSIZE_WORD;
        htrans      = mfp_bus_pkg::HTRANS_IDLE;
        hwdata      = '0;
        hwrite      = 1'b0;
        io_switches = '0;
        io_buttons  = '0;
        repeat (RESET_CYCLES) @(posedge hclk);
        @(negedge hclk);
        rst = 1'b0;

        test_reset();
        test_word_rw();
        test_lanes();
        test_pipelined();
        test_gpio();
        test_unmapped();

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- files.f
src/mfp_bus_pkg.sv
src/mfp_map_pkg.sv
src/ahb_slave_if.sv
src/ahb_select_stage.sv
src/ahb_ram_slave.sv
src/ahb_gpio_slave.sv
src/ahb_response_mux.sv
src/mfp_ahb_lite_matrix.sv
dv/tb_matrix.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_matrix
FLAGS     ?= --binary --timing --assert --timescale 1ns/100ps

FILELIST := files.f
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST)))
BIN      := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
